/* design/linebuf_pkg.sv */
package linebuf_pkg;

  localparam int WORD_W      = 32;
  localparam int LINE_W      = 128;
  localparam int MEM_ADDR_W  = 26;
  localparam int BYTE_OFS_W  = 4;
  localparam int NUM_ENTRIES = 16;
  localparam int ENTRY_W     = 4;
  localparam int MASK_W      = 4;

  typedef logic [WORD_W-1:0]                word_t;
  typedef logic [LINE_W-1:0]                line_t;
  typedef logic [WORD_W-1:0]                bus_addr_t;
  typedef logic [MEM_ADDR_W-1:0]            mem_addr_t;

  // line number, byte offset stripped
  typedef logic [MEM_ADDR_W-BYTE_OFS_W-1:0] line_tag_t;

  typedef logic [ENTRY_W-1:0]               entry_idx_t;
  typedef logic [MASK_W-1:0]                byte_mask_t;

  // one request on the data bus
  typedef struct packed {
    logic       write;
    bus_addr_t  addr;
    word_t      wdata;
    byte_mask_t rd_mask;
    byte_mask_t wr_mask;
  } membus_req_t;

  // line controller states
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    LOAD_WAIT,
    UPDATE,
    SETTLE_0,
    SETTLE_1
  } ctrl_state_t;

endpackage

/* design/lru_tracker.sv */
`timescale 1ns/1ps

module lru_tracker (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    touch_i,
  input  linebuf_pkg::entry_idx_t entry_i,
  output linebuf_pkg::entry_idx_t lru_o
);

  // age 0 is most recent, all ones is the victim
  logic [linebuf_pkg::ENTRY_W-1:0] age      [linebuf_pkg::NUM_ENTRIES];
  logic [linebuf_pkg::ENTRY_W-1:0] age_next [linebuf_pkg::NUM_ENTRIES];
  logic [linebuf_pkg::ENTRY_W-1:0] touched_age;
  linebuf_pkg::entry_idx_t         lru_next;

  always_comb
  begin
    touched_age = age[entry_i];
    lru_next    = lru_o;
    for (int i = 0; i < linebuf_pkg::NUM_ENTRIES; i++)
    begin
      age_next[i] = age[i];
      if (touch_i)
      begin
        if (linebuf_pkg::entry_idx_t'(i) == entry_i)
        begin
          age_next[i] = '0;
        end
        else if (age[i] < touched_age)
        begin
          age_next[i] = age[i] + 1'b1;
        end
      end
      if (age_next[i] == '1)
      begin
        lru_next = linebuf_pkg::entry_idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < linebuf_pkg::NUM_ENTRIES; i++)
      begin
        age[i] <= linebuf_pkg::entry_idx_t'(i);
      end
      lru_o <= '1;
    end
    else
    begin
      age   <= age_next;
      lru_o <= lru_next;
    end
  end

endmodule

/* design/line_store.sv */
`timescale 1ns/1ps

module line_store (
  input  logic                    clk,
  input  logic                    rst,

  input  linebuf_pkg::line_tag_t  tag_i,
  input  linebuf_pkg::entry_idx_t entry_i,

  input  logic                    fill_i,
  input  linebuf_pkg::line_t      fill_line_i,

  input  logic                    wr_i,
  input  logic                    rd_i,
  input  logic [1:0]              word_sel_i,
  input  linebuf_pkg::word_t      wdata_i,
  input  linebuf_pkg::byte_mask_t wr_mask_i,
  input  linebuf_pkg::byte_mask_t rd_mask_i,

  output logic                    hit_o,
  output linebuf_pkg::entry_idx_t hit_entry_o,
  output logic                    free_valid_o,
  output linebuf_pkg::entry_idx_t free_entry_o,

  output linebuf_pkg::word_t      rdata_o
);

  logic [linebuf_pkg::NUM_ENTRIES-1:0] valid;
  linebuf_pkg::line_tag_t              tags  [linebuf_pkg::NUM_ENTRIES];
  linebuf_pkg::line_t                  lines [linebuf_pkg::NUM_ENTRIES];

  linebuf_pkg::line_t                  cur_line;
  linebuf_pkg::line_t                  merged_line;
  linebuf_pkg::word_t                  cur_word;
  linebuf_pkg::word_t                  masked_word;

  // tag match and first free slot, lowest index wins
  always_comb
  begin
    hit_o        = 1'b0;
    hit_entry_o  = '0;
    free_valid_o = 1'b0;
    free_entry_o = '0;
    for (int i = linebuf_pkg::NUM_ENTRIES - 1; i >= 0; i--)
    begin
      if (valid[i] && (tags[i] == tag_i))
      begin
        hit_o       = 1'b1;
        hit_entry_o = linebuf_pkg::entry_idx_t'(i);
      end
      if (!valid[i])
      begin
        free_valid_o = 1'b1;
        free_entry_o = linebuf_pkg::entry_idx_t'(i);
      end
    end
  end

  assign cur_line = lines[entry_i];
  assign cur_word = cur_line[word_sel_i * linebuf_pkg::WORD_W +: linebuf_pkg::WORD_W];

  always_comb
  begin
    merged_line = cur_line;
    for (int b = 0; b < linebuf_pkg::MASK_W; b++)
    begin
      if (wr_mask_i[b])
      begin
        merged_line[word_sel_i * linebuf_pkg::WORD_W + b * 8 +: 8] = wdata_i[b * 8 +: 8];
      end
      masked_word[b * 8 +: 8] = rd_mask_i[b] ? cur_word[b * 8 +: 8] : 8'h00;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid <= '0;
    end
    else if (fill_i)
    begin
      valid[entry_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill_i)
    begin
      lines[entry_i] <= fill_line_i;
      tags[entry_i]  <= tag_i;
    end
    else if (wr_i)
    begin
      lines[entry_i] <= merged_line;
    end
    // read sees the line as it was before this edge
    if (rd_i)
    begin
      rdata_o <= masked_word;
    end
  end

endmodule

/* design/line_ctrl.sv */
`timescale 1ns/1ps

module line_ctrl (
  input  logic                     clk,
  input  logic                     rst,

  input  logic                     req_i,
  input  linebuf_pkg::membus_req_t cmd_i,
  output logic                     ack_o,

  input  logic                     hit_i,
  input  linebuf_pkg::entry_idx_t  hit_entry_i,
  input  logic                     free_valid_i,
  input  linebuf_pkg::entry_idx_t  free_entry_i,
  input  linebuf_pkg::entry_idx_t  lru_entry_i,

  output linebuf_pkg::line_tag_t   tag_o,
  output linebuf_pkg::entry_idx_t  entry_o,
  output logic                     fill_o,
  output logic                     wr_o,
  output logic                     rd_o,
  output logic [1:0]               word_sel_o,
  output linebuf_pkg::word_t       wdata_o,
  output linebuf_pkg::byte_mask_t  wr_mask_o,
  output linebuf_pkg::byte_mask_t  rd_mask_o,

  output logic                     touch_o,

  output logic                     fill_start_o,
  input  logic                     fill_done_i
);

  linebuf_pkg::ctrl_state_t state;
  linebuf_pkg::membus_req_t cmd_stgd;
  logic                     req_stgd;
  linebuf_pkg::entry_idx_t  entry;

  // request staging, held until served
  always_ff @(posedge clk)
  begin
    if (req_i)
    begin
      cmd_stgd <= cmd_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= linebuf_pkg::IDLE;
      req_stgd <= 1'b0;
      touch_o  <= 1'b0;
      ack_o    <= 1'b0;
    end
    else
    begin
      touch_o <= 1'b0;
      ack_o   <= 1'b0;

      case (state)
        linebuf_pkg::IDLE:
        begin
          if (req_stgd)
          begin
            touch_o <= 1'b1;
            if (hit_i)
            begin
              entry <= hit_entry_i;
              state <= linebuf_pkg::UPDATE;
            end
            else
            begin
              // prefer an empty slot over evicting
              entry <= free_valid_i ? free_entry_i : lru_entry_i;
              state <= linebuf_pkg::LOAD;
            end
          end
        end
        linebuf_pkg::LOAD:
        begin
          state <= linebuf_pkg::LOAD_WAIT;
        end
        linebuf_pkg::LOAD_WAIT:
        begin
          if (fill_done_i)
          begin
            state <= linebuf_pkg::UPDATE;
          end
        end
        linebuf_pkg::UPDATE:
        begin
          req_stgd <= 1'b0;
          ack_o    <= 1'b1;
          state    <= linebuf_pkg::SETTLE_0;
        end
        linebuf_pkg::SETTLE_0:
        begin
          state <= linebuf_pkg::SETTLE_1;
        end
        default:
        begin
          state <= linebuf_pkg::IDLE;
        end
      endcase

      // a new request overrides the clear in UPDATE
      if (req_i)
      begin
        req_stgd <= 1'b1;
      end
    end
  end

  assign tag_o        = cmd_stgd.addr[linebuf_pkg::MEM_ADDR_W-1:linebuf_pkg::BYTE_OFS_W];
  assign entry_o      = entry;
  assign fill_start_o = (state == linebuf_pkg::LOAD);
  assign fill_o       = (state == linebuf_pkg::LOAD_WAIT) && fill_done_i;
  assign rd_o         = (state == linebuf_pkg::UPDATE);
  assign wr_o         = rd_o && cmd_stgd.write;
  assign word_sel_o   = cmd_stgd.addr[linebuf_pkg::BYTE_OFS_W-1:2];
  assign wdata_o      = cmd_stgd.wdata;
  assign wr_mask_o    = cmd_stgd.wr_mask;
  assign rd_mask_o    = cmd_stgd.rd_mask;

endmodule

/* design/avl_read_master.sv */
`timescale 1ns/1ps

module avl_read_master (
  input  logic                   clk,
  input  logic                   rst,

  input  logic                   fill_start_i,
  input  linebuf_pkg::line_tag_t fill_tag_i,
  output logic                   fill_done_o,
  output linebuf_pkg::line_t     fill_line_o,

  input  logic                   avl_ready_i,
  output logic                   avl_read_o,
  output linebuf_pkg::mem_addr_t avl_addr_o,
  input  logic                   avl_rdata_valid_i,
  input  linebuf_pkg::line_t     avl_rdata_i
);

  typedef enum logic [1:0] {
    M_IDLE,
    M_REQUEST,
    M_RECEIVE
  } master_state_t;

  master_state_t state;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state       <= M_IDLE;
      avl_read_o  <= 1'b0;
      fill_done_o <= 1'b0;
    end
    else
    begin
      fill_done_o <= 1'b0;
      case (state)
        M_IDLE:
        begin
          if (fill_start_i)
          begin
            avl_read_o <= 1'b1;
            state      <= M_REQUEST;
          end
        end
        M_REQUEST:
        begin
          // held until the memory takes it
          if (avl_ready_i)
          begin
            avl_read_o <= 1'b0;
            state      <= M_RECEIVE;
          end
        end
        M_RECEIVE:
        begin
          if (avl_rdata_valid_i)
          begin
            fill_done_o <= 1'b1;
            state       <= M_IDLE;
          end
        end
        default:
        begin
          state <= M_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == M_IDLE) && fill_start_i)
    begin
      avl_addr_o <= {fill_tag_i, {linebuf_pkg::BYTE_OFS_W{1'b0}}};
    end
    if ((state == M_RECEIVE) && avl_rdata_valid_i)
    begin
      fill_line_o <= avl_rdata_i;
    end
  end

endmodule

/* design/linebuf_top.sv */
`timescale 1ns/1ps

module linebuf_top (
  input  logic                     clk,
  input  logic                     rst,

  input  logic                     req_i,
  input  linebuf_pkg::membus_req_t cmd_i,
  output logic                     ack_o,
  output linebuf_pkg::word_t       rdata_o,

  input  logic                     avl_ready_i,
  output logic                     avl_read_o,
  output linebuf_pkg::mem_addr_t   avl_addr_o,
  input  logic                     avl_rdata_valid_i,
  input  linebuf_pkg::line_t       avl_rdata_i
);

  linebuf_pkg::line_tag_t  tag;
  linebuf_pkg::entry_idx_t entry;
  linebuf_pkg::entry_idx_t hit_entry;
  linebuf_pkg::entry_idx_t free_entry;
  linebuf_pkg::entry_idx_t lru_entry;
  logic                    hit;
  logic                    free_valid;
  logic                    fill;
  logic                    wr;
  logic                    rd;
  logic [1:0]              word_sel;
  linebuf_pkg::word_t      wdata;
  linebuf_pkg::byte_mask_t wr_mask;
  linebuf_pkg::byte_mask_t rd_mask;
  logic                    touch;
  logic                    fill_start;
  logic                    fill_done;
  linebuf_pkg::line_t      fill_line;

  line_ctrl u_ctrl (
    .clk, .rst, .req_i, .cmd_i, .ack_o,
    .hit_i(hit), .hit_entry_i(hit_entry),
    .free_valid_i(free_valid), .free_entry_i(free_entry), .lru_entry_i(lru_entry),
    .tag_o(tag), .entry_o(entry),
    .fill_o(fill), .wr_o(wr), .rd_o(rd),
    .word_sel_o(word_sel), .wdata_o(wdata), .wr_mask_o(wr_mask), .rd_mask_o(rd_mask),
    .touch_o(touch),
    .fill_start_o(fill_start), .fill_done_i(fill_done)
  );

  line_store u_store (
    .clk, .rst,
    .tag_i(tag), .entry_i(entry),
    .fill_i(fill), .fill_line_i(fill_line),
    .wr_i(wr), .rd_i(rd),
    .word_sel_i(word_sel), .wdata_i(wdata), .wr_mask_i(wr_mask), .rd_mask_i(rd_mask),
    .hit_o(hit), .hit_entry_o(hit_entry),
    .free_valid_o(free_valid), .free_entry_o(free_entry),
    .rdata_o
  );

  lru_tracker u_lru (
    .clk, .rst, .touch_i(touch), .entry_i(entry), .lru_o(lru_entry)
  );

  // fills always fetch the staged request's line
  avl_read_master u_master (
    .clk, .rst,
    .fill_start_i(fill_start), .fill_tag_i(tag),
    .fill_done_o(fill_done), .fill_line_o(fill_line),
    .avl_ready_i, .avl_read_o, .avl_addr_o, .avl_rdata_valid_i, .avl_rdata_i
  );

endmodule

/* bench/avl_mem_stub.sv */
`timescale 1ns/1ps

module avl_mem_stub (
  input  logic                   clk,
  input  logic                   rst,
  input  int                     stall_i,
  input  logic                   avl_read_i,
  input  linebuf_pkg::mem_addr_t avl_addr_i,
  output logic                   avl_ready_o,
  output logic                   avl_rdata_valid_o,
  output linebuf_pkg::line_t     avl_rdata_o,
  output linebuf_pkg::mem_addr_t last_addr_o,
  output int                     reads_o
);

  // word k of line t is t*4+k with a fixed pattern on top
  function automatic linebuf_pkg::line_t make_line(input linebuf_pkg::mem_addr_t addr);
    linebuf_pkg::line_t line;
    linebuf_pkg::word_t tag;
    tag = linebuf_pkg::word_t'(addr[linebuf_pkg::MEM_ADDR_W-1:linebuf_pkg::BYTE_OFS_W]);
    for (int k = 0; k < 4; k++)
    begin
      line[k * 32 +: 32] = (tag * 4 + k) ^ 32'h5a5a0000;
    end
    return line;
  endfunction

  initial
  begin
    avl_ready_o       = 1'b0;
    avl_rdata_valid_o = 1'b0;
    avl_rdata_o       = '0;
    last_addr_o       = '0;
    reads_o           = 0;
    forever
    begin
      @(posedge clk);
      #1;
      if (!rst && avl_read_i)
      begin
        last_addr_o = avl_addr_i;
        repeat (stall_i)
        begin
          @(posedge clk);
          #1;
        end
        avl_ready_o = 1'b1;
        // accepted at this edge
        @(posedge clk);
        #1;
        avl_ready_o = 1'b0;
        reads_o     = reads_o + 1;
        repeat (2)
        begin
          @(posedge clk);
          #1;
        end
        avl_rdata_o       = make_line(last_addr_o);
        avl_rdata_valid_o = 1'b1;
        @(posedge clk);
        #1;
        avl_rdata_valid_o = 1'b0;
      end
    end
  end

endmodule

/* bench/tb_linebuf.sv */
`timescale 1ns/1ps

module tb_linebuf;

  localparam int ACK_TIMEOUT = 200;
  localparam int NUM = linebuf_pkg::NUM_ENTRIES;

  logic                     clk;
  logic                     rst;
  logic                     req;
  linebuf_pkg::membus_req_t cmd;
  logic                     ack;
  linebuf_pkg::word_t       rdata;
  logic                     avl_ready;
  logic                     avl_read;
  linebuf_pkg::mem_addr_t   avl_addr;
  logic                     avl_rdata_valid;
  linebuf_pkg::line_t       avl_rdata;
  linebuf_pkg::mem_addr_t   last_addr;
  int                       mem_reads;
  int                       stall;

  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int          test_errors;
  int          test_checks;
  logic        timed_out;

  // reference model of the 16 entries
  logic                   m_valid [NUM];
  linebuf_pkg::line_tag_t m_tag   [NUM];
  linebuf_pkg::word_t     m_data  [NUM][4];
  logic [3:0]             m_age   [NUM];
  int                     m_reads;

  linebuf_top uut (
    .clk, .rst, .req_i(req), .cmd_i(cmd), .ack_o(ack), .rdata_o(rdata),
    .avl_ready_i(avl_ready), .avl_read_o(avl_read), .avl_addr_o(avl_addr),
    .avl_rdata_valid_i(avl_rdata_valid), .avl_rdata_i(avl_rdata)
  );

  avl_mem_stub u_mem (
    .clk, .rst, .stall_i(stall), .avl_read_i(avl_read), .avl_addr_i(avl_addr),
    .avl_ready_o(avl_ready), .avl_rdata_valid_o(avl_rdata_valid),
    .avl_rdata_o(avl_rdata), .last_addr_o(last_addr), .reads_o(mem_reads)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd0000001) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic linebuf_pkg::word_t line_word(input linebuf_pkg::line_tag_t t, input int k);
    return (linebuf_pkg::word_t'(t) * 4 + k) ^ 32'h5a5a0000;
  endfunction

  function automatic linebuf_pkg::membus_req_t build_req(input logic write,
      input linebuf_pkg::line_tag_t t, input logic [1:0] ws, input linebuf_pkg::word_t wdata,
      input linebuf_pkg::byte_mask_t rd_mask, input linebuf_pkg::byte_mask_t wr_mask);
    linebuf_pkg::membus_req_t c;
    c.write   = write;
    c.addr    = {6'b0, t, ws, 2'b00};
    c.wdata   = wdata;
    c.rd_mask = rd_mask;
    c.wr_mask = wr_mask;
    return c;
  endfunction

  function automatic linebuf_pkg::membus_req_t random_req(input linebuf_pkg::line_tag_t base);
    logic                   write;
    linebuf_pkg::line_tag_t t;
    logic [1:0]             ws;
    linebuf_pkg::word_t     wdata;
    logic [3:0]             rd_mask;
    logic [3:0]             wr_mask;
    write   = rand_bits(1);
    t       = base + rand_bits(5);
    ws      = rand_bits(2);
    wdata   = rand_bits(32);
    rd_mask = rand_bits(4);
    wr_mask = rand_bits(4);
    return build_req(write, t, ws, wdata, rd_mask, wr_mask);
  endfunction

  function automatic void model_reset();
    for (int i = 0; i < NUM; i++)
    begin
      m_valid[i] = 1'b0;
      m_age[i]   = 4'(i);
    end
  endfunction

  // returns the expected read word and applies the request to the model
  function automatic void model_access(input linebuf_pkg::membus_req_t c,
      output linebuf_pkg::word_t exp);
    linebuf_pkg::line_tag_t t;
    linebuf_pkg::word_t     w;
    int                     ws;
    int                     e;
    int                     old_age;
    t  = c.addr[linebuf_pkg::MEM_ADDR_W-1:linebuf_pkg::BYTE_OFS_W];
    ws = c.addr[3:2];
    e  = -1;
    for (int i = 0; i < NUM; i++)
    begin
      if (m_valid[i] && m_tag[i] == t)
      begin
        e = i;
      end
    end
    if (e < 0)
    begin
      for (int i = NUM - 1; i >= 0; i--)
      begin
        if (!m_valid[i])
        begin
          e = i;
        end
      end
      // without a free entry the oldest goes and its writes are dropped
      if (e < 0)
      begin
        for (int i = 0; i < NUM; i++)
        begin
          if (m_age[i] == 4'hf)
          begin
            e = i;
          end
        end
      end
      m_valid[e] = 1'b1;
      m_tag[e]   = t;
      for (int k = 0; k < 4; k++)
      begin
        m_data[e][k] = line_word(t, k);
      end
      m_reads++;
    end
    old_age = m_age[e];
    for (int i = 0; i < NUM; i++)
    begin
      if (i == e)
      begin
        m_age[i] = 4'h0;
      end
      else if (m_age[i] < old_age)
      begin
        m_age[i] = m_age[i] + 4'h1;
      end
    end
    w = m_data[e][ws];
    for (int b = 0; b < 4; b++)
    begin
      exp[b * 8 +: 8] = c.rd_mask[b] ? w[b * 8 +: 8] : 8'h00;
      if (c.write && c.wr_mask[b])
      begin
        m_data[e][ws][b * 8 +: 8] = c.wdata[b * 8 +: 8];
      end
    end
  endfunction

  function automatic void tally(input logic ok);
    checks++;
    test_checks++;
    if (!ok)
    begin
      errors++;
      test_errors++;
    end
  endfunction

  task automatic compare_word(input string name, input linebuf_pkg::word_t exp,
      input linebuf_pkg::word_t act);
    tally(exp === act);
    if (exp !== act)
    begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic compare_count(input string name, input int exp, input int act);
    tally(exp == act);
    if (exp != act)
    begin
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic report_test(input string name);
    $display("%-16s %0d checks, %0d errors", name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic reset_dut();
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    model_reset();
  endtask

  // one request and the two settle cycles with ack_o low
  task automatic drive_request(input linebuf_pkg::membus_req_t c, input string name,
      output linebuf_pkg::word_t got, output int lat);
    int cycles;
    got    = '0;
    lat    = 0;
    cycles = 0;
    req    = 1'b1;
    cmd    = c;
    @(posedge clk);
    #1;
    req = 1'b0;
    while (ack !== 1'b1 && cycles < ACK_TIMEOUT)
    begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (ack !== 1'b1)
    begin
      $display("%s: no acknowledge within %0d cycles", name, ACK_TIMEOUT);
      timed_out = 1'b1;
      tally(1'b0);
    end
    else
    begin
      got = rdata;
      lat = cycles;
      repeat (2)
      begin
        @(posedge clk);
        #1;
        if (ack !== 1'b0)
        begin
          $display("%s: ack_o did not drop after one cycle", name);
          tally(1'b0);
        end
      end
    end
  endtask

  task automatic access(input linebuf_pkg::membus_req_t c, input string name,
      output linebuf_pkg::word_t got);
    linebuf_pkg::word_t exp;
    int                 lat;
    int                 reads_before;
    got = '0;
    if (!timed_out)
    begin
      reads_before = m_reads;
      model_access(c, exp);
      drive_request(c, name, got, lat);
      // writes return the word as it was before the merge
      if (!timed_out)
      begin
        compare_word(name, exp, got);
      end
      // hits answer on a fixed schedule
      if (!timed_out && m_reads == reads_before)
      begin
        compare_count({name, " latency"}, 2, lat);
      end
    end
  endtask

  initial
  begin
    linebuf_pkg::line_tag_t t;
    linebuf_pkg::line_tag_t base;
    linebuf_pkg::word_t     got;
    linebuf_pkg::word_t     wdata;
    logic [1:0]             ws;
    logic [3:0]             mask;
    int                     reads_before;
    req         = 1'b0;
    cmd         = '0;
    stall       = 0;
    rst         = 1'b1;
    lfsr        = 32'hffaca4e4;
    errors      = 0;
    checks      = 0;
    test_errors = 0;
    test_checks = 0;
    timed_out   = 1'b0;
    m_reads     = 0;
    reset_dut();

    t            = rand_bits(22);
    ws           = rand_bits(2);
    mask         = rand_bits(4);
    reads_before = mem_reads;
    access(build_req(1'b0, t, ws, '0, mask, '0), "read miss", got);
    compare_count("read miss fetches", 1, mem_reads - reads_before);
    compare_word("read miss address", linebuf_pkg::word_t'({t, 4'h0}),
                 linebuf_pkg::word_t'(last_addr));
    report_test("read_miss");

    ws           = rand_bits(2);
    reads_before = mem_reads;
    access(build_req(1'b0, t, ws, '0, 4'hf, '0), "read hit", got);
    compare_count("read hit fetches", 0, mem_reads - reads_before);
    report_test("read_hit");

    ws    = rand_bits(2);
    wdata = rand_bits(32);
    mask  = rand_bits(4);
    access(build_req(1'b1, t, ws, wdata, 4'hf, mask), "masked write", got);
    access(build_req(1'b0, t, ws, '0, 4'hf, '0), "merged read", got);
    report_test("write_merge");

    reset_dut();
    base = rand_bits(22);
    access(build_req(1'b1, base, 2'd0, rand_bits(32), 4'hf, 4'hf), "evict write", got);
    for (int i = 1; i <= 16; i++)
    begin
      access(build_req(1'b0, base + i, 2'd0, '0, 4'hf, '0), "evict fill", got);
    end
    reads_before = mem_reads;
    access(build_req(1'b0, base + 15, 2'd1, '0, 4'hf, '0), "recent line", got);
    compare_count("recent line fetches", 0, mem_reads - reads_before);
    access(build_req(1'b0, base, 2'd0, '0, 4'hf, '0), "evicted line", got);
    compare_count("evicted line fetches", 1, mem_reads - reads_before);
    compare_word("evicted write lost", line_word(base, 0), got);
    report_test("lru_evict");

    base = rand_bits(22);
    for (int i = 0; i < 24; i++)
    begin
      stall = rand_bits(4);
      access(random_req(base), "stalled access", got);
    end
    compare_count("stalled fetches", m_reads, mem_reads);
    report_test("ready_stall");

    base = rand_bits(22);
    for (int i = 0; i < 400; i++)
    begin
      stall = rand_bits(2);
      access(random_req(base), "random access", got);
    end
    compare_count("random fetches", m_reads, mem_reads);
    report_test("random_mix");

    $display("total %0d checks, %0d errors", checks, errors);
    if (errors == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
design/linebuf_pkg.sv
design/lru_tracker.sv
design/line_store.sv
design/line_ctrl.sv
design/avl_read_master.sv
design/linebuf_top.sv
bench/avl_mem_stub.sv
bench/tb_linebuf.sv

/* Bender.yml */
package:
  name: linebuf

sources:
  - design/linebuf_pkg.sv
  - design/lru_tracker.sv
  - design/line_store.sv
  - design/line_ctrl.sv
  - design/avl_read_master.sv
  - design/linebuf_top.sv
  - target: test
    files:
      - bench/avl_mem_stub.sv
      - bench/tb_linebuf.sv
